//--- rtl/fetch_pkg.sv
package fetch_pkg;

	// byte address width of the core
	localparam int ADDR_W = 64;

	// base instruction width, no compressed forms
	localparam int INST_W = 32;

	// one read beat holds two instructions
	localparam int BEAT_W = 64;

	// response code width, same as the AXI read channel
	localparam int RESP_W = 2;

	// byte address
	typedef logic [ADDR_W-1:0] addr_t;

	// instruction word
	typedef logic [INST_W-1:0] inst_t;

	// memory read beat
	typedef logic [BEAT_W-1:0] beat_t;

	// read response
	typedef logic [RESP_W-1:0] resp_t;

	// response codes
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

endpackage

//--- rtl/if_stage.sv
`timescale 1ns/1ps

module if_stage #(
	parameter int CNT_W = 4
) (
	input  logic             clk,
	input  logic             cnt_rst,
	input  fetch_pkg::addr_t pc,
	input  logic             fetch_valid,
	input  logic             id_ready,
	input  logic             bubble_id,
	input  logic             bubble_ex,
	input  logic             bubble_mem,
	input  logic             replay,
	input  fetch_pkg::addr_t replay_pc,
	input  logic             r_valid,
	input  fetch_pkg::beat_t r_data,
	input  fetch_pkg::addr_t r_addr,
	input  fetch_pkg::resp_t r_resp,
	output logic             id_valid,
	output fetch_pkg::addr_t id_pc,
	output fetch_pkg::inst_t id_inst,
	output fetch_pkg::addr_t id_snpc,
	output logic             id_fault
);
	import fetch_pkg::*;

	logic             handshake;
	logic             bubble_any;
	logic             cnt_clr;
	logic             cnt_max;
	logic [CNT_W-1:0] bubble_cnt;
	logic             rsp_err;
	logic             squash;
	inst_t            inst_sel;

	assign handshake  = fetch_valid & id_ready;
	assign bubble_any = bubble_id | bubble_ex | bubble_mem;
	assign rsp_err    = (r_resp == RESP_SLVERR);

	// a response closes the bubble window
	assign cnt_clr = r_valid;

	// static next pc, replay restarts behind the replayed instruction
	always_comb begin
		if (replay) begin
			id_snpc = replay_pc + 64'd12;
		end else begin
			id_snpc = pc + 64'd4;
		end
	end

	// word select, bit 2 picks the upper half
	always_comb begin
		if (r_addr[2]) begin
			inst_sel = r_data[63:32];
		end else begin
			inst_sel = r_data[31:0];
		end
	end

	// bubble counter
	// saturates so a long stall never looks clean again
	assign cnt_max = &bubble_cnt;

	always_ff @(posedge clk) begin
		if (cnt_rst || cnt_clr) begin
			bubble_cnt <= '0;
		end else if (bubble_any && !cnt_max) begin
			bubble_cnt <= bubble_cnt + CNT_W'(1);
		end
	end

	// word is stale or bad, hand decode a zero instruction
	assign squash = rsp_err || bubble_any || (bubble_cnt != '0);

	always_ff @(posedge clk) begin
		if (cnt_rst) begin
			id_valid <= 1'b0;
			id_fault <= 1'b0;
		end else if (handshake) begin
			if (r_valid) begin
				id_valid <= 1'b1;
				id_fault <= rsp_err;
			end else begin
				// previous word consumed, nothing new yet
				id_valid <= 1'b0;
				id_fault <= 1'b0;
			end
		end
	end

	// payload to decode
	always_ff @(posedge clk) begin
		if (handshake && r_valid) begin
			id_pc <= r_addr;
			if (squash) begin
				id_inst <= '0;
			end else begin
				id_inst <= inst_sel;
			end
		end
	end

endmodule

//--- rtl/imem.sv
`timescale 1ns/1ps

module imem #(
	parameter fetch_pkg::addr_t RESET_PC   = 64'h0000_0000_8000_0000,
	parameter int               IMEM_WORDS = 256,
	parameter int               MEM_LAT    = 2
) (
	input  logic                          clk,
	input  logic                          cnt_rst,
	input  logic                          req,
	input  fetch_pkg::addr_t              req_addr,
	input  logic                          load_we,
	input  logic [$clog2(IMEM_WORDS)-1:0] load_idx,
	input  fetch_pkg::beat_t              load_data,
	output logic                          r_valid,
	output fetch_pkg::beat_t              r_data,
	output fetch_pkg::addr_t              r_addr,
	output fetch_pkg::resp_t              r_resp
);
	import fetch_pkg::*;

	localparam int IDX_W = $clog2(IMEM_WORDS);

	beat_t mem [IMEM_WORDS];

	addr_t            offset;
	logic             in_range;
	logic [IDX_W-1:0] rd_idx;
	beat_t            rd_data;
	resp_t            rd_resp;

	// latency pipe, valid bits plus the payload of each stage
	logic [MEM_LAT-1:0] vld_q;
	addr_t              addr_q [MEM_LAT];
	beat_t              data_q [MEM_LAT];
	resp_t              resp_q [MEM_LAT];

	// beat index relative to the reset vector
	assign offset   = req_addr - RESET_PC;
	assign in_range = (req_addr >= RESET_PC) && (offset[63:3] < 61'(IMEM_WORDS));
	assign rd_idx   = offset[IDX_W+2:3];

	always_comb begin
		if (in_range) begin
			rd_data = mem[rd_idx];
			rd_resp = RESP_OKAY;
		end else begin
			// outside the array, slave error with zero data
			rd_data = '0;
			rd_resp = RESP_SLVERR;
		end
	end

	// load port
	always_ff @(posedge clk) begin
		if (load_we) begin
			mem[load_idx] <= load_data;
		end
	end

	always_ff @(posedge clk) begin
		if (cnt_rst) begin
			vld_q <= '0;
		end else begin
			vld_q[0] <= req;
			for (int i = 1; i < MEM_LAT; i++) begin
				vld_q[i] <= vld_q[i-1];
			end
		end
	end

	// data sampled when the request is taken
	always_ff @(posedge clk) begin
		addr_q[0] <= req_addr;
		data_q[0] <= rd_data;
		resp_q[0] <= rd_resp;
		for (int i = 1; i < MEM_LAT; i++) begin
			addr_q[i] <= addr_q[i-1];
			data_q[i] <= data_q[i-1];
			resp_q[i] <= resp_q[i-1];
		end
	end

	assign r_valid = vld_q[MEM_LAT-1];
	assign r_data  = data_q[MEM_LAT-1];
	assign r_addr  = addr_q[MEM_LAT-1];
	assign r_resp  = resp_q[MEM_LAT-1];

endmodule

//--- rtl/pc_gen.sv
`timescale 1ns/1ps

module pc_gen #(
	parameter fetch_pkg::addr_t RESET_PC = 64'h0000_0000_8000_0000
) (
	input  logic             clk,
	input  logic             cnt_rst,
	input  logic             r_valid,
	input  logic             id_ready,
	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_pc,
	input  fetch_pkg::addr_t snpc,
	output logic             req,
	output fetch_pkg::addr_t req_addr,
	output fetch_pkg::addr_t pc,
	output logic             fetch_valid
);
	import fetch_pkg::*;

	// idle only right after reset, then alternates between issue and wait
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT
	} state_t;

	state_t state;
	state_t state_nxt;
	addr_t  pc_q;
	addr_t  pc_nxt;
	logic   wait_rsp;
	logic   advance;

	// one read in flight
	assign wait_rsp = (state == ST_WAIT);

	// decode took the word, so move on
	assign advance = wait_rsp && r_valid && id_ready;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				state_nxt = ST_REQ;
			end
			ST_REQ: begin
				state_nxt = ST_WAIT;
			end
			ST_WAIT: begin
				// reissue on response, same address if decode stalled
				if (r_valid) begin
					state_nxt = ST_REQ;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	// branch target wins over the static next pc
	always_comb begin
		if (redirect) begin
			pc_nxt = redirect_pc;
		end else begin
			pc_nxt = snpc;
		end
	end

	always_ff @(posedge clk) begin
		if (cnt_rst) begin
			state <= ST_IDLE;
			pc_q  <= RESET_PC;
		end else begin
			state <= state_nxt;
			if (advance) begin
				pc_q <= pc_nxt;
			end
		end
	end

	// single-cycle request pulse
	assign req         = (state == ST_REQ);
	assign req_addr    = pc_q;
	assign pc          = pc_q;
	assign fetch_valid = (state != ST_IDLE);

endmodule

//--- rtl/rv_fetch_top.sv
`timescale 1ns/1ps

module rv_fetch_top #(
	parameter fetch_pkg::addr_t RESET_PC   = 64'h0000_0000_8000_0000,
	parameter int               IMEM_WORDS = 256,
	parameter int               MEM_LAT    = 2,
	parameter int               CNT_W      = 4
) (
	input  logic                          clk,
	input  logic                          cnt_rst,
	input  logic                          id_ready,
	input  logic                          bubble_id,
	input  logic                          bubble_ex,
	input  logic                          bubble_mem,
	input  logic                          replay,
	input  fetch_pkg::addr_t              replay_pc,
	input  logic                          redirect,
	input  fetch_pkg::addr_t              redirect_pc,
	input  logic                          load_we,
	input  logic [$clog2(IMEM_WORDS)-1:0] load_idx,
	input  fetch_pkg::beat_t              load_data,
	output logic                          id_valid,
	output fetch_pkg::addr_t              id_pc,
	output fetch_pkg::inst_t              id_inst,
	output fetch_pkg::addr_t              id_snpc,
	output logic                          id_fault
);
	import fetch_pkg::*;

	// request side
	logic  req;
	addr_t req_addr;
	addr_t pc;
	logic  fetch_valid;

	// response side
	logic  r_valid;
	beat_t r_data;
	addr_t r_addr;
	resp_t r_resp;

	pc_gen #(
		.RESET_PC(RESET_PC)
	) u_pc_gen (
		.clk        (clk),
		.cnt_rst    (cnt_rst),
		.r_valid    (r_valid),
		.id_ready   (id_ready),
		.redirect   (redirect),
		.redirect_pc(redirect_pc),
		.snpc       (id_snpc),
		.req        (req),
		.req_addr   (req_addr),
		.pc         (pc),
		.fetch_valid(fetch_valid)
	);

	// stands in for the AXI read channel
	imem #(
		.RESET_PC  (RESET_PC),
		.IMEM_WORDS(IMEM_WORDS),
		.MEM_LAT   (MEM_LAT)
	) u_imem (
		.clk      (clk),
		.cnt_rst  (cnt_rst),
		.req      (req),
		.req_addr (req_addr),
		.load_we  (load_we),
		.load_idx (load_idx),
		.load_data(load_data),
		.r_valid  (r_valid),
		.r_data   (r_data),
		.r_addr   (r_addr),
		.r_resp   (r_resp)
	);

	if_stage #(
		.CNT_W(CNT_W)
	) u_if_stage (
		.clk        (clk),
		.cnt_rst    (cnt_rst),
		.pc         (pc),
		.fetch_valid(fetch_valid),
		.id_ready   (id_ready),
		.bubble_id  (bubble_id),
		.bubble_ex  (bubble_ex),
		.bubble_mem (bubble_mem),
		.replay     (replay),
		.replay_pc  (replay_pc),
		.r_valid    (r_valid),
		.r_data     (r_data),
		.r_addr     (r_addr),
		.r_resp     (r_resp),
		.id_valid   (id_valid),
		.id_pc      (id_pc),
		.id_inst    (id_inst),
		.id_snpc    (id_snpc),
		.id_fault   (id_fault)
	);

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the rv_fetch testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_rv_fetch \
	-Mdir obj_dir -o tb_rv_fetch \
	-f rv_fetch.f > build.log 2>&1
status=$?
if [ "$status" -ne 0 ]; then
	cat build.log
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/tb_rv_fetch > sim.log 2>&1
status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "simulation passed"
exit 0

//--- rv_fetch.f
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/imem.sv
rtl/if_stage.sv
rtl/rv_fetch_top.sv
test/rv_fetch_sva.sv
test/tb_rv_fetch.sv

//--- test/rv_fetch_sva.sv
`timescale 1ns/1ps

module rv_fetch_sva (
	input logic             clk,
	input logic             cnt_rst,
	input logic             id_ready,
	input logic             id_valid,
	input logic             id_fault,
	input fetch_pkg::addr_t id_pc,
	input fetch_pkg::inst_t id_inst
);

	// outputs to decode come out of reset cleared
	a_rst_valid: assert property (@(posedge clk) cnt_rst |=> !id_valid)
		else $error("id_valid high after a reset cycle");

	// a faulting fetch carries no instruction
	a_fault_zero: assert property (@(posedge clk) disable iff (cnt_rst)
		id_fault |-> (id_inst == '0))
		else $error("id_inst nonzero while id_fault is set");

	// decode stalled, flags hold
	a_hold_flags: assert property (@(posedge clk) disable iff (cnt_rst)
		!id_ready |=> ($stable(id_valid) && $stable(id_fault)))
		else $error("id_valid or id_fault changed while id_ready was low");

	// payload holds as long as a word is on offer
	a_hold_data: assert property (@(posedge clk) disable iff (cnt_rst)
		(!id_ready && id_valid) |=> ($stable(id_pc) && $stable(id_inst)))
		else $error("id_pc or id_inst changed while id_ready was low");

endmodule

bind if_stage rv_fetch_sva u_sva (
	.clk     (clk),
	.cnt_rst (cnt_rst),
	.id_ready(id_ready),
	.id_valid(id_valid),
	.id_fault(id_fault),
	.id_pc   (id_pc),
	.id_inst (id_inst)
);

//--- test/tb_rv_fetch.sv
`timescale 1ns/1ps

module tb_rv_fetch;
	import fetch_pkg::*;

	localparam addr_t RESET_PC   = 64'h0000_0000_8000_0000;
	localparam int    IMEM_WORDS = 256;
	localparam int    MEM_LAT    = 2;
	localparam int    CNT_W      = 4;
	localparam int    IDX_W      = $clog2(IMEM_WORDS);

	localparam int     RST_CYC   = 16;
	localparam int     QUIET_CYC = 40;
	localparam int     RAND_CYC  = 3000;
	localparam int     TOTAL_CYC = RST_CYC + IMEM_WORDS + QUIET_CYC + RAND_CYC;
	localparam longint WD_NS     = (longint'(TOTAL_CYC) * (MEM_LAT + 2) + 100) * 20;

	// stimulus modes
	localparam int MODE_RESET = 0;
	localparam int MODE_FILL  = 1;
	localparam int MODE_QUIET = 2;
	localparam int MODE_RAND  = 3;

	// model request phases
	localparam int PH_IDLE  = 0;
	localparam int PH_ISSUE = 1;
	localparam int PH_WAIT  = 2;

	logic             clk;
	logic             cnt_rst;
	logic             id_ready;
	logic             bubble_id;
	logic             bubble_ex;
	logic             bubble_mem;
	logic             replay;
	addr_t            replay_pc;
	logic             redirect;
	addr_t            redirect_pc;
	logic             load_we;
	logic [IDX_W-1:0] load_idx;
	beat_t            load_data;
	logic             id_valid;
	addr_t            id_pc;
	inst_t            id_inst;
	addr_t            id_snpc;
	logic             id_fault;

	logic [31:0] lfsr;
	beat_t       mem_copy [IMEM_WORDS];
	int          fill_idx;

	// reference model state
	int    m_phase;
	int    m_lat;
	addr_t m_pc;
	addr_t m_raddr;
	logic  m_stale;
	logic  m_valid;
	logic  m_fault;
	logic  m_loaded;
	addr_t m_id_pc;
	inst_t m_id_inst;

	// what the random phase actually reached
	int n_clean;
	int n_squash;
	int n_fault;
	int n_redirect;
	int n_replay;
	int n_stall;

	rv_fetch_top #(
		.RESET_PC  (RESET_PC),
		.IMEM_WORDS(IMEM_WORDS),
		.MEM_LAT   (MEM_LAT),
		.CNT_W     (CNT_W)
	) dut (
		.clk        (clk),
		.cnt_rst    (cnt_rst),
		.id_ready   (id_ready),
		.bubble_id  (bubble_id),
		.bubble_ex  (bubble_ex),
		.bubble_mem (bubble_mem),
		.replay     (replay),
		.replay_pc  (replay_pc),
		.redirect   (redirect),
		.redirect_pc(redirect_pc),
		.load_we    (load_we),
		.load_idx   (load_idx),
		.load_data  (load_data),
		.id_valid   (id_valid),
		.id_pc      (id_pc),
		.id_inst    (id_inst),
		.id_snpc    (id_snpc),
		.id_fault   (id_fault)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// one in eight targets lands outside the memory
	function automatic addr_t pick_target();
		addr_t idx;
		addr_t half;
		if (rand_bits(3) == 32'd0) begin
			idx = addr_t'(rand_bits(4));
			if (rand_bits(1) == 32'd0) begin
				return RESET_PC - (idx << 3) - 64'd8;
			end
			return RESET_PC + (addr_t'(IMEM_WORDS) << 3) + (idx << 2);
		end
		idx  = addr_t'(rand_bits(IDX_W));
		half = addr_t'(rand_bits(1));
		return RESET_PC + (idx << 3) + (half << 2);
	endfunction

	function automatic addr_t expect_snpc(input addr_t pc_v, input logic rp, input addr_t rp_pc);
		return rp ? rp_pc + 64'd12 : pc_v + 64'd4;
	endfunction

	task automatic lookup_beat(input addr_t a, output beat_t d, output logic err);
		addr_t off;
		off = a - RESET_PC;
		err = !(a >= RESET_PC && off < (addr_t'(IMEM_WORDS) << 3));
		d   = err ? '0 : mem_copy[off[IDX_W+2:3]];
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			fail_run($sformatf("** Error: %s is %h, expected %h at %0t", name, got, exp, $time));
		end
	endtask

	task automatic check_inst(input string name, input inst_t got, input inst_t exp);
		if (got !== exp) begin
			fail_run($sformatf("** Error: %s is %h, expected %h at %0t", name, got, exp, $time));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("** Error: %s is %h, expected %h at %0t", name, got, exp, $time));
		end
	endtask

	// advance the model over one clock edge with the inputs seen at that edge
	task automatic model_step();
		logic  rv;
		logic  bub;
		logic  err;
		beat_t beat;
		addr_t nxt;
		rv  = (m_phase == PH_WAIT) && (m_lat == 0);
		bub = bubble_id || bubble_ex || bubble_mem;
		nxt = expect_snpc(m_pc, replay, replay_pc);
		if (cnt_rst) begin
			m_phase = PH_IDLE;
			m_pc    = RESET_PC;
			m_stale = 1'b0;
			m_valid = 1'b0;
			m_fault = 1'b0;
		end else begin
			if (m_phase != PH_IDLE && id_ready) begin
				m_valid = rv;
				m_fault = 1'b0;
				if (rv) begin
					lookup_beat(m_raddr, beat, err);
					m_fault  = err;
					m_id_pc  = m_raddr;
					m_loaded = 1'b1;
					if (err || bub || m_stale) begin
						m_id_inst = '0;
						if (err) n_fault++;
						else n_squash++;
					end else begin
						m_id_inst = m_raddr[2] ? beat[63:32] : beat[31:0];
						n_clean++;
					end
				end
			end
			// any bubble since the last response makes the next word stale
			if (rv) begin
				m_stale = 1'b0;
			end else if (bub) begin
				m_stale = 1'b1;
			end
			case (m_phase)
				PH_IDLE: m_phase = PH_ISSUE;
				PH_ISSUE: begin
					m_raddr = m_pc;
					m_lat   = MEM_LAT - 1;
					m_phase = PH_WAIT;
				end
				default: begin
					if (!rv) begin
						m_lat--;
					end else begin
						m_phase = PH_ISSUE;
						if (!id_ready) begin
							n_stall++;
						end else if (redirect) begin
							m_pc = redirect_pc;
							n_redirect++;
						end else begin
							m_pc = nxt;
							if (replay) n_replay++;
						end
					end
				end
			endcase
		end
	endtask

	task automatic drive(input int mode);
		logic [31:0] hi;
		logic [31:0] lo;
		cnt_rst     = (mode == MODE_RESET);
		load_we     = 1'b0;
		id_ready    = (mode == MODE_QUIET);
		redirect    = 1'b0;
		replay      = 1'b0;
		bubble_id   = 1'b0;
		bubble_ex   = 1'b0;
		bubble_mem  = 1'b0;
		if (mode == MODE_FILL) begin
			hi        = rand_bits(32);
			lo        = rand_bits(32);
			load_we   = 1'b1;
			load_idx  = IDX_W'(fill_idx);
			load_data = {hi, lo};
			mem_copy[fill_idx] = {hi, lo};
			fill_idx++;
		end else if (mode == MODE_RAND) begin
			id_ready    = (rand_bits(2) != 32'd0);
			redirect    = (rand_bits(3) == 32'd7);
			redirect_pc = pick_target();
			replay      = (rand_bits(4) == 32'd0);
			replay_pc   = pick_target();
			bubble_id   = (rand_bits(4) == 32'd0);
			bubble_ex   = (rand_bits(4) == 32'd0);
			bubble_mem  = (rand_bits(4) == 32'd0);
		end
	endtask

	task automatic check_outputs();
		check_bit("id_valid", id_valid, m_valid);
		check_bit("id_fault", id_fault, m_fault);
		check_addr("id_snpc", id_snpc, expect_snpc(m_pc, replay, replay_pc));
		if (m_loaded) begin
			check_addr("id_pc", id_pc, m_id_pc);
			check_inst("id_inst", id_inst, m_id_inst);
		end
	endtask

	task automatic step_cycle(input int mode);
		@(posedge clk);
		model_step();
		#2;
		drive(mode);
		#16;
		check_outputs();
	endtask

	initial begin
		#(WD_NS);
		fail_run($sformatf("watchdog expired after %0d ns, the run did not finish", WD_NS));
	end

	initial begin
		lfsr        = 32'h8a06_be5a;
		cnt_rst     = 1'b1;
		id_ready    = 1'b0;
		bubble_id   = 1'b0;
		bubble_ex   = 1'b0;
		bubble_mem  = 1'b0;
		replay      = 1'b0;
		replay_pc   = '0;
		redirect    = 1'b0;
		redirect_pc = '0;
		load_we     = 1'b0;
		load_idx    = '0;
		load_data   = '0;
		fill_idx    = 0;
		m_loaded    = 1'b0;
		n_clean     = 0;
		n_squash    = 0;
		n_fault     = 0;
		n_redirect  = 0;
		n_replay    = 0;
		n_stall     = 0;
		// the initial level already covers the first edge
		repeat (RST_CYC - 1) step_cycle(MODE_RESET);
		// fetches stall on id_ready while the memory fills
		repeat (IMEM_WORDS) step_cycle(MODE_FILL);
		repeat (QUIET_CYC) step_cycle(MODE_QUIET);
		repeat (RAND_CYC) step_cycle(MODE_RAND);
		if (n_clean > 0 && n_squash > 0 && n_fault > 0 && n_redirect > 0 &&
			n_replay > 0 && n_stall > 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			fail_run($sformatf("stimulus missed a case: clean %0d squash %0d fault %0d %s %0d %0d %0d",
				n_clean, n_squash, n_fault, "redirect/replay/stall", n_redirect, n_replay,
				n_stall));
		end
	end

endmodule
